/* common/nts_frame_pkg.sv */
// Frame storage package with receive beat types, bank addressing and bank states
`default_nettype none

package nts_frame_pkg;

  localparam int BUF_ADDR_W = 8;   // 256 words per bank
  localparam int WORD_W     = 64;
  localparam int KEEP_W     = 8;

  typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

  // One beat as it leaves the MAC
  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic [KEEP_W-1:0] keep;
  } rx_beat_t;

  // Beat after byte-order correction
  typedef struct packed {
    logic              beat;   // Any byte valid
    logic [WORD_W-1:0] data;   // Left-aligned
    logic [KEEP_W-1:0] keep;   // Mask as received
  } rx_word_t;

  typedef enum logic [2:0] {
    EMPTY,
    HAS_DATA,
    RECEIVED,
    OFFER,
    READ_INIT,
    READ_OUT,
    READ_LAST,
    READ_DONE
  } bank_state_t;

endpackage

`default_nettype wire

/* common/nts_api_pkg.sv */
// Register API package with address map, identity words and statistics events
`default_nettype none

package nts_api_pkg;

  localparam int API_ADDR_W = 12;
  localparam int API_DATA_W = 32;

  localparam logic [API_ADDR_W-1:0] ADDR_NAME0          = 12'h000;
  localparam logic [API_ADDR_W-1:0] ADDR_NAME1          = 12'h001;
  localparam logic [API_ADDR_W-1:0] ADDR_VERSION        = 12'h002;
  localparam logic [API_ADDR_W-1:0] ADDR_DUMMY          = 12'h003;
  localparam logic [API_ADDR_W-1:0] ADDR_BYTES_MSB      = 12'h00A;
  localparam logic [API_ADDR_W-1:0] ADDR_BYTES_LSB      = 12'h00B;
  localparam logic [API_ADDR_W-1:0] ADDR_FRAMES_MSB     = 12'h020;
  localparam logic [API_ADDR_W-1:0] ADDR_FRAMES_LSB     = 12'h021;
  localparam logic [API_ADDR_W-1:0] ADDR_GOOD_MSB       = 12'h022;
  localparam logic [API_ADDR_W-1:0] ADDR_GOOD_LSB       = 12'h023;
  localparam logic [API_ADDR_W-1:0] ADDR_BAD_MSB        = 12'h024;
  localparam logic [API_ADDR_W-1:0] ADDR_BAD_LSB        = 12'h025;
  localparam logic [API_ADDR_W-1:0] ADDR_DISPATCHED_MSB = 12'h026;
  localparam logic [API_ADDR_W-1:0] ADDR_DISPATCHED_LSB = 12'h027;

  localparam logic [63:0] CORE_NAME    = 64'h4E54_532D_4449_5350;   // NTS-DISP
  localparam logic [31:0] CORE_VERSION = 32'h302E_3032;             // 0.02

  // Statistics counter slots
  localparam int CNT_FRAMES     = 0;
  localparam int CNT_GOOD       = 1;
  localparam int CNT_BAD        = 2;
  localparam int CNT_DISPATCHED = 3;
  localparam int CNT_BYTES      = 4;
  localparam int NUM_CNT        = 5;

  typedef struct packed {
    logic       sof;
    logic [3:0] nbytes;
  } rx_stat_t;

endpackage

`default_nettype wire

/* rx/nts_rx_frontend.sv */
// Receive front end that left-aligns the last word, counts bytes and detects frame start
`default_nettype none
`timescale 1ns/10ps

module nts_rx_frontend (
  input  wire                     i_clk,
  input  wire                     i_areset,
  input  wire nts_frame_pkg::rx_beat_t i_beat,
  output nts_frame_pkg::rx_word_t o_word,
  output logic                    o_sof,
  output nts_api_pkg::rx_stat_t   o_stat
);

  import nts_frame_pkg::*;

  logic [KEEP_W-1:0] prev_keep;
  logic [3:0]        nbytes;
  logic [3:0]        pad;      // Empty bytes below the payload

  // --------------------------------------------------------------------
  // Keep mask decode
  // --------------------------------------------------------------------
  always_comb
  begin
    case (i_beat.keep)
      8'hFF:   nbytes = 4'd8;
      8'h7F:   nbytes = 4'd7;
      8'h3F:   nbytes = 4'd6;
      8'h1F:   nbytes = 4'd5;
      8'h0F:   nbytes = 4'd4;
      8'h07:   nbytes = 4'd3;
      8'h03:   nbytes = 4'd2;
      8'h01:   nbytes = 4'd1;
      default: nbytes = 4'd0;   // Idle or odd mask
    endcase
  end

  assign pad = 4'd8 - nbytes;

  // Move the valid low bytes to the top of the word
  assign o_word.data = (nbytes == 4'd0) ? i_beat.data : (i_beat.data << {pad, 3'b000});
  assign o_word.keep = i_beat.keep;
  assign o_word.beat = |i_beat.keep;

  // --------------------------------------------------------------------
  // Start of frame
  // --------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      prev_keep <= '1;   // Non-zero so no false 00 to FF step
    else
      prev_keep <= i_beat.keep;
  end

  assign o_sof = (prev_keep == '0) && (i_beat.keep == '1);

  assign o_stat.sof    = o_sof;
  assign o_stat.nbytes = nbytes;

endmodule

`default_nettype wire

/* buffer/nts_bank_ram.sv */
// Frame bank memory with synchronous read and a write-priority address select
`default_nettype none
`timescale 1ns/10ps

module nts_bank_ram (
  input  wire                               i_clk,
  input  wire                               i_write,
  input  wire nts_frame_pkg::buf_addr_t     i_waddr,
  input  wire nts_frame_pkg::buf_addr_t     i_raddr,
  input  wire  [nts_frame_pkg::WORD_W-1:0]  i_wdata,
  output logic [nts_frame_pkg::WORD_W-1:0]  o_rdata
);

  import nts_frame_pkg::*;

  logic [WORD_W-1:0] mem [2**BUF_ADDR_W];
  buf_addr_t         addr;

  // Single port, the writer wins
  assign addr = i_write ? i_waddr : i_raddr;

  always_ff @(posedge i_clk)
  begin
    if (i_write)
      mem[addr] <= i_wdata;
    o_rdata <= mem[addr];
  end

endmodule

`default_nettype wire

/* buffer/nts_frame_buffer.sv */
// Frame buffer with two alternating banks, bank swap and dispatch word readout
`default_nettype none
`timescale 1ns/10ps

module nts_frame_buffer (
  input  wire                               i_clk,
  input  wire                               i_areset,
  input  wire nts_frame_pkg::rx_word_t      i_word,
  input  wire                               i_sof,
  input  wire                               i_good,
  input  wire                               i_bad,
  input  wire                               i_rd_start,
  input  wire                               i_discard,
  output logic                              o_available,
  output nts_frame_pkg::buf_addr_t          o_counter,
  output logic [nts_frame_pkg::KEEP_W-1:0]  o_keep,
  output logic                              o_empty,
  output logic                              o_rd_valid,
  output logic [nts_frame_pkg::WORD_W-1:0]  o_rd_data
);

  import nts_frame_pkg::*;

  bank_state_t       state     [2];
  buf_addr_t         count     [2];   // Index of last stored word
  logic [KEEP_W-1:0] last_keep [2];
  logic [WORD_W-1:0] rdata     [2];
  logic              rx_sel;          // Bank owned by the MAC side
  logic              rd_sel;
  logic              wr_go;
  buf_addr_t         waddr;
  buf_addr_t         raddr;
  logic              rd_pend;         // RAM output holds a word to emit

  assign rd_sel = ~rx_sel;

  // --------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------
  always_comb
  begin
    wr_go = 1'b0;
    waddr = count[rx_sel] + buf_addr_t'(1);
    case (state[rx_sel])
      EMPTY:
      begin
        wr_go = i_sof;   // First beat of a frame
        waddr = '0;
      end
      HAS_DATA: wr_go = i_word.beat && (count[rx_sel] != '1);
      default:  wr_go = 1'b0;
    endcase
  end

  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    nts_bank_ram u_bank (
      .i_clk   (i_clk),
      .i_write (wr_go && (rx_sel == 1'(b))),
      .i_waddr (waddr),
      .i_raddr (raddr),
      .i_wdata (i_word.data),
      .o_rdata (rdata[b])
    );
  end

  // --------------------------------------------------------------------
  // Bank state machines
  // --------------------------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      rx_sel       <= 1'b0;
      state[0]     <= EMPTY;
      state[1]     <= EMPTY;
      count[0]     <= '0;
      count[1]     <= '0;
      last_keep[0] <= '0;
      last_keep[1] <= '0;
      raddr        <= '0;
      rd_pend      <= 1'b0;
      o_rd_valid   <= 1'b0;
    end
    else
    begin
      // Receiving bank
      if (i_bad)
      begin
        state[rx_sel]     <= EMPTY;
        count[rx_sel]     <= '0;
        last_keep[rx_sel] <= '0;
      end
      else
      begin
        case (state[rx_sel])
          EMPTY:
            if (i_sof)
            begin
              count[rx_sel] <= '0;
              if (i_good)
              begin
                last_keep[rx_sel] <= i_word.keep;   // Single beat frame
                state[rx_sel]     <= RECEIVED;
              end
              else
                state[rx_sel] <= HAS_DATA;
            end
          HAS_DATA:
          begin
            if (wr_go)
              count[rx_sel] <= waddr;
            if (i_good)
            begin
              last_keep[rx_sel] <= i_word.keep;
              state[rx_sel]     <= RECEIVED;
            end
          end
          RECEIVED:
            if (state[rd_sel] == EMPTY)
            begin
              state[rx_sel] <= OFFER;
              rx_sel        <= ~rx_sel;   // Swap banks
            end
          default: ;
        endcase
      end

      // Reading bank
      if (i_discard)
        state[rd_sel] <= EMPTY;
      else
      begin
        case (state[rd_sel])
          OFFER:
          begin
            raddr <= '0;
            if (i_rd_start)
              state[rd_sel] <= READ_INIT;
          end
          READ_INIT: state[rd_sel] <= READ_OUT;
          READ_OUT:
            if (raddr == count[rd_sel])
              state[rd_sel] <= READ_LAST;
            else
              raddr <= raddr + buf_addr_t'(1);
          READ_LAST:
            if (!rd_pend)
              state[rd_sel] <= READ_DONE;   // Last word has left the output
          default: ;
        endcase
      end

      rd_pend    <= (state[rd_sel] == READ_OUT) && !i_discard;
      o_rd_valid <= rd_pend && !i_discard;
    end
  end

  always_ff @(posedge i_clk)
  begin
    o_rd_data <= rdata[rd_sel];
  end

  assign o_available = (state[rd_sel] == OFFER);
  assign o_counter   = count[rd_sel];
  assign o_keep      = last_keep[rd_sel];
  assign o_empty     = !(state[rd_sel] inside {OFFER, READ_INIT, READ_OUT, READ_LAST});

endmodule

`default_nettype wire

/* logic/nts_api_regs.sv */
// API register block with statistics counters, LSB snapshots and scratch register
`default_nettype none
`timescale 1ns/10ps

module nts_api_regs (
  input  wire                                 i_clk,
  input  wire                                 i_areset,
  input  wire nts_api_pkg::rx_stat_t          i_stat,
  input  wire                                 i_good,
  input  wire                                 i_bad,
  input  wire                                 i_rd_start,
  input  wire                                 i_cs,
  input  wire                                 i_we,
  input  wire  [nts_api_pkg::API_ADDR_W-1:0]  i_addr,
  input  wire  [nts_api_pkg::API_DATA_W-1:0]  i_wdata,
  output logic [nts_api_pkg::API_DATA_W-1:0]  o_rdata
);

  import nts_api_pkg::*;

  logic [63:0]           cnt     [NUM_CNT];
  logic [API_DATA_W-1:0] cnt_lsb [NUM_CNT];   // Latched on MSB read
  logic [3:0]            cnt_inc [NUM_CNT];
  logic [NUM_CNT-1:0]    snap_we;
  logic [API_DATA_W-1:0] dummy;
  logic                  dummy_we;

  // --------------------------------------------------------------------
  // Event increments
  // --------------------------------------------------------------------
  always_comb
  begin
    cnt_inc[CNT_FRAMES]     = {3'b000, i_stat.sof};
    cnt_inc[CNT_GOOD]       = {3'b000, i_good};
    cnt_inc[CNT_BAD]        = {3'b000, i_bad};
    cnt_inc[CNT_DISPATCHED] = {3'b000, i_rd_start};
    cnt_inc[CNT_BYTES]      = i_stat.nbytes;
  end

  assign dummy_we = i_cs && i_we && (i_addr == ADDR_DUMMY);

  // --------------------------------------------------------------------
  // Read decode
  // --------------------------------------------------------------------
  always_comb
  begin
    o_rdata = '0;
    snap_we = '0;
    if (i_cs && !i_we)
    begin
      case (i_addr)
        ADDR_NAME0:   o_rdata = CORE_NAME[63:32];
        ADDR_NAME1:   o_rdata = CORE_NAME[31:0];
        ADDR_VERSION: o_rdata = CORE_VERSION;
        ADDR_DUMMY:   o_rdata = dummy;
        ADDR_BYTES_MSB:
        begin
          o_rdata            = cnt[CNT_BYTES][63:32];
          snap_we[CNT_BYTES] = 1'b1;
        end
        ADDR_BYTES_LSB: o_rdata = cnt_lsb[CNT_BYTES];
        ADDR_FRAMES_MSB:
        begin
          o_rdata             = cnt[CNT_FRAMES][63:32];
          snap_we[CNT_FRAMES] = 1'b1;
        end
        ADDR_FRAMES_LSB: o_rdata = cnt_lsb[CNT_FRAMES];
        ADDR_GOOD_MSB:
        begin
          o_rdata           = cnt[CNT_GOOD][63:32];
          snap_we[CNT_GOOD] = 1'b1;
        end
        ADDR_GOOD_LSB: o_rdata = cnt_lsb[CNT_GOOD];
        ADDR_BAD_MSB:
        begin
          o_rdata          = cnt[CNT_BAD][63:32];
          snap_we[CNT_BAD] = 1'b1;
        end
        ADDR_BAD_LSB: o_rdata = cnt_lsb[CNT_BAD];
        ADDR_DISPATCHED_MSB:
        begin
          o_rdata                 = cnt[CNT_DISPATCHED][63:32];
          snap_we[CNT_DISPATCHED] = 1'b1;
        end
        ADDR_DISPATCHED_LSB: o_rdata = cnt_lsb[CNT_DISPATCHED];
        default: o_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      dummy <= '0;
      for (int i = 0; i < NUM_CNT; i++)
      begin
        cnt[i]     <= '0;
        cnt_lsb[i] <= '0;
      end
    end
    else
    begin
      if (dummy_we)
        dummy <= i_wdata;
      for (int i = 0; i < NUM_CNT; i++)
      begin
        cnt[i] <= cnt[i] + 64'(cnt_inc[i]);
        if (snap_we[i])
          cnt_lsb[i] <= cnt[i][31:0];   // Live value, before this edge's increment
      end
    end
  end

endmodule

`default_nettype wire

/* logic/nts_dispatcher.sv */
// Receive dispatcher top joining the MAC front end, frame buffer and API registers
`default_nettype none
`timescale 1ns/10ps

module nts_dispatcher (
  input  wire                                   i_clk,
  input  wire                                   i_areset,
  // MAC receive
  input  wire [nts_frame_pkg::WORD_W-1:0]       i_rx_data,
  input  wire [nts_frame_pkg::KEEP_W-1:0]       i_rx_data_valid,
  input  wire                                   i_rx_good_frame,
  input  wire                                   i_rx_bad_frame,
  // Dispatch stream
  output wire                                   o_dispatch_packet_available,
  output wire nts_frame_pkg::buf_addr_t         o_dispatch_counter,
  output wire [nts_frame_pkg::KEEP_W-1:0]       o_dispatch_data_valid,
  output wire                                   o_dispatch_fifo_empty,
  output wire                                   o_dispatch_fifo_rd_valid,
  output wire [nts_frame_pkg::WORD_W-1:0]       o_dispatch_fifo_rd_data,
  input  wire                                   i_dispatch_fifo_rd_start,
  input  wire                                   i_dispatch_packet_read_discard,
  // Register API
  input  wire                                   i_api_cs,
  input  wire                                   i_api_we,
  input  wire [nts_api_pkg::API_ADDR_W-1:0]     i_api_address,
  input  wire [nts_api_pkg::API_DATA_W-1:0]     i_api_write_data,
  output wire [nts_api_pkg::API_DATA_W-1:0]     o_api_read_data
);

  import nts_frame_pkg::*;
  import nts_api_pkg::*;

  rx_beat_t rx_beat;
  rx_word_t rx_word;
  logic     rx_sof;
  rx_stat_t rx_stat;

  assign rx_beat.data = i_rx_data;
  assign rx_beat.keep = i_rx_data_valid;

  nts_rx_frontend u_rx_frontend (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_beat   (rx_beat),
    .o_word   (rx_word),
    .o_sof    (rx_sof),
    .o_stat   (rx_stat)
  );

  nts_frame_buffer u_frame_buffer (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_word      (rx_word),
    .i_sof       (rx_sof),
    .i_good      (i_rx_good_frame),
    .i_bad       (i_rx_bad_frame),
    .i_rd_start  (i_dispatch_fifo_rd_start),
    .i_discard   (i_dispatch_packet_read_discard),
    .o_available (o_dispatch_packet_available),
    .o_counter   (o_dispatch_counter),
    .o_keep      (o_dispatch_data_valid),
    .o_empty     (o_dispatch_fifo_empty),
    .o_rd_valid  (o_dispatch_fifo_rd_valid),
    .o_rd_data   (o_dispatch_fifo_rd_data)
  );

  nts_api_regs u_api_regs (
    .i_clk      (i_clk),
    .i_areset   (i_areset),
    .i_stat     (rx_stat),
    .i_good     (i_rx_good_frame),
    .i_bad      (i_rx_bad_frame),
    .i_rd_start (i_dispatch_fifo_rd_start),
    .i_cs       (i_api_cs),
    .i_we       (i_api_we),
    .i_addr     (i_api_address),
    .i_wdata    (i_api_write_data),
    .o_rdata    (o_api_read_data)
  );

endmodule

`default_nettype wire

/* sim/tb_clkgen.sv */
// Testbench clock and reset generator for the dispatcher
`default_nettype none
`timescale 1ns/10ps

module tb_clkgen (
  output logic o_clk,
  output logic o_areset
);

  localparam int HALF_PERIOD = 50;   // 100 ns clock
  localparam int RESET_CYCLES = 10;

  initial
  begin
    o_clk = 1'b0;
    forever
      #HALF_PERIOD o_clk = ~o_clk;
  end

  // Release lines up with the stimulus drive point
  initial
  begin
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #10;
    o_areset = 1'b0;
  end

endmodule

`default_nettype wire

/* sim/nts_dispatcher_assert.sv */
// Frame buffer assertions on readout valid, discard and frame offer
`default_nettype none
`timescale 1ns/10ps

module nts_dispatcher_assert (
  input wire i_clk,
  input wire i_areset,
  input wire i_discard,
  input wire i_rd_valid,
  input wire i_empty,
  input wire i_available
);

  // ------------------------------------------------------------------
  // Readout stream
  // ------------------------------------------------------------------

  // Words only flow while a frame is held
  a_valid_not_empty: assert property (
    @(posedge i_clk) disable iff (i_areset) i_rd_valid |-> !i_empty
  ) else $error("rd_valid high while fifo_empty is high");

  a_discard_stops: assert property (
    @(posedge i_clk) disable iff (i_areset) i_discard |=> !i_rd_valid
  ) else $error("rd_valid still high in the cycle after a discard");

  // Offer ends before the stream starts
  a_offer_xor_valid: assert property (
    @(posedge i_clk) disable iff (i_areset) !(i_available && i_rd_valid)
  ) else $error("packet_available and rd_valid high together");

endmodule

`default_nettype wire

/* sim/tb_nts_dispatcher.sv */
// Testbench for the receive dispatcher with random frames, a reference model and counter checks
`default_nettype none
`timescale 1ns/10ps

module tb_nts_dispatcher;

  import nts_frame_pkg::*;
  import nts_api_pkg::*;

  localparam int WAIT_LIMIT = 200;   // Cycles any single wait may take
  localparam int NUM_FRAMES = 16;

  logic                  clk;
  logic                  areset;
  logic [WORD_W-1:0]     rx_data;
  logic [KEEP_W-1:0]     rx_keep;
  logic                  rx_good;
  logic                  rx_bad;
  logic                  rd_start;
  logic                  discard;
  logic                  api_cs;
  logic                  api_we;
  logic [API_ADDR_W-1:0] api_addr;
  logic [API_DATA_W-1:0] api_wdata;
  logic                  available;
  buf_addr_t             counter;
  logic [KEEP_W-1:0]     data_valid;
  logic                  fifo_empty;
  logic                  rd_valid;
  logic [WORD_W-1:0]     rd_data;
  logic [API_DATA_W-1:0] api_rdata;

  // Reference model state
  logic [31:0]       lfsr;
  logic [KEEP_W-1:0] model_prev_keep;
  logic [63:0]       exp_frames;
  logic [63:0]       exp_good;
  logic [63:0]       exp_bad;
  logic [63:0]       exp_disp;
  logic [63:0]       exp_bytes;
  logic [63:0]       exp_words [$];
  int                exp_len_q [$];
  logic [KEEP_W-1:0] exp_keep_q [$];
  int                checks;
  int                errors;

  tb_clkgen u_clkgen (
    .o_clk    (clk),
    .o_areset (areset)
  );

  nts_dispatcher u_nts_dispatcher (
    .i_clk                          (clk),
    .i_areset                       (areset),
    .i_rx_data                      (rx_data),
    .i_rx_data_valid                (rx_keep),
    .i_rx_good_frame                (rx_good),
    .i_rx_bad_frame                 (rx_bad),
    .o_dispatch_packet_available    (available),
    .o_dispatch_counter             (counter),
    .o_dispatch_data_valid          (data_valid),
    .o_dispatch_fifo_empty          (fifo_empty),
    .o_dispatch_fifo_rd_valid       (rd_valid),
    .o_dispatch_fifo_rd_data        (rd_data),
    .i_dispatch_fifo_rd_start       (rd_start),
    .i_dispatch_packet_read_discard (discard),
    .i_api_cs                       (api_cs),
    .i_api_we                       (api_we),
    .i_api_address                  (api_addr),
    .i_api_write_data               (api_wdata),
    .o_api_read_data                (api_rdata)
  );

  bind nts_frame_buffer nts_dispatcher_assert u_fb_assert (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_discard   (i_discard),
    .i_rd_valid  (o_rd_valid),
    .i_empty     (o_empty),
    .i_available (o_available)
  );

  // ------------------------------------------------------------------
  // Model helpers
  // ------------------------------------------------------------------

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[62:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
    end
    return v;
  endfunction

  // Contiguous low ones give their count, anything else zero
  function automatic logic [3:0] mask_bytes(input logic [KEEP_W-1:0] keep);
    logic [3:0] n;
    n = 4'd0;
    for (int k = 1; k <= 8; k++)
      if (keep == (8'hFF >> (8 - k)))
        n = 4'(k);
    return n;
  endfunction

  function automatic logic [63:0] left_align(input logic [63:0] data, input logic [3:0] n);
    logic [63:0] w;
    w = data;
    for (int s = int'(n); s < 8; s++)
      w = {w[55:0], 8'h00};   // One byte up per empty lane
    return w;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic give_up(input string why);
    $display("ERROR at %0t: timed out while %s", $time, why);
    $display("test failed");
    $finish;
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d error(s)", name, errors - err_before);
  endtask

  task automatic after_edge();
    @(posedge clk);
    #10;
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  task automatic drive_beat(input logic [63:0] data, input logic [7:0] keep,
                            input logic good, input logic bad);
    after_edge();
    rx_data = data;
    rx_keep = keep;
    rx_good = good;
    rx_bad  = bad;
    if (model_prev_keep == 8'h00 && keep == 8'hFF)
      exp_frames++;
    exp_bytes = exp_bytes + 64'(mask_bytes(keep));
    if (good)
      exp_good++;
    if (bad)
      exp_bad++;
    model_prev_keep = keep;
  endtask

  task automatic pick_frame(output int len, output logic [7:0] keep);
    int n;
    len  = int'(take_bits(5) % 64'd20) + 1;
    n    = int'(take_bits(3)) + 1;
    keep = 8'hFF >> (8 - n);
    if (len == 1)
      keep = 8'hFF;   // Lone beat is also the full first beat
  endtask

  task automatic send_frame(input int len, input logic [7:0] last_keep, input logic bad);
    logic [63:0] raw;
    logic [7:0]  keep;
    logic        last;
    drive_beat('0, 8'h00, 1'b0, 1'b0);   // Idle gap
    for (int b = 0; b < len; b++)
    begin
      raw  = take_bits(64);
      last = (b == len - 1);
      keep = last ? last_keep : 8'hFF;
      drive_beat(raw, keep, last && !bad, last && bad);
      if (!bad)
        exp_words.push_back(left_align(raw, mask_bytes(keep)));
    end
    drive_beat('0, 8'h00, 1'b0, 1'b0);
    if (!bad)
    begin
      exp_len_q.push_back(len);
      exp_keep_q.push_back(last_keep);
    end
  endtask

  task automatic wait_available();
    int n;
    n = 0;
    @(negedge clk);
    while (!available)
    begin
      n++;
      if (n > WAIT_LIMIT)
        give_up("waiting for packet_available");
      @(negedge clk);
    end
  endtask

  task automatic read_frame();
    int          len;
    int          lat;
    int          got;
    logic [7:0]  keep;
    logic [63:0] exp;
    len  = exp_len_q.pop_front();
    keep = exp_keep_q.pop_front();
    check_val("o_dispatch_counter", 64'(len - 1), 64'(counter));
    check_val("o_dispatch_data_valid", 64'(keep), 64'(data_valid));
    check_val("o_dispatch_fifo_empty", 64'd0, 64'(fifo_empty));
    after_edge();
    rd_start = 1'b1;
    exp_disp++;
    after_edge();
    rd_start = 1'b0;
    lat = 0;   // Edges since rd_start was sampled
    @(negedge clk);
    while (!rd_valid)
    begin
      lat++;
      if (lat > WAIT_LIMIT)
        give_up("waiting for rd_valid to rise");
      @(negedge clk);
    end
    check_val("o_dispatch_fifo_rd_valid latency", 64'd3, 64'(lat));
    got = 0;
    while (rd_valid)
    begin
      if (got < len)
      begin
        exp = exp_words.pop_front();
        check_val("o_dispatch_fifo_rd_data", exp, rd_data);
      end
      got++;
      if (got > WAIT_LIMIT)
        give_up("waiting for rd_valid to fall");
      @(negedge clk);
    end
    for (int k = got; k < len; k++)
      exp = exp_words.pop_front();   // Drop words never seen
    check_val("o_dispatch_fifo_rd_valid words", 64'(len), 64'(got));
    check_val("o_dispatch_fifo_empty", 64'd1, 64'(fifo_empty));
  endtask

  task automatic discard_frame();
    after_edge();
    discard = 1'b1;
    after_edge();
    discard = 1'b0;
  endtask

  // Start the stream, then discard while words are still flowing
  task automatic cut_frame();
    int          len;
    int          n;
    logic [7:0]  keep;
    logic [63:0] exp;
    len  = exp_len_q.pop_front();
    keep = exp_keep_q.pop_front();
    after_edge();
    rd_start = 1'b1;
    exp_disp++;
    after_edge();
    rd_start = 1'b0;
    n = 0;
    @(negedge clk);
    while (!rd_valid)
    begin
      n++;
      if (n > WAIT_LIMIT)
        give_up("waiting for rd_valid before discard");
      @(negedge clk);
    end
    discard_frame();
    check_val("o_dispatch_fifo_rd_valid", 64'd0, 64'(rd_valid));
    check_val("o_dispatch_fifo_empty", 64'd1, 64'(fifo_empty));
    for (int k = 0; k < len; k++)
      exp = exp_words.pop_front();
  endtask

  task automatic watch_no_offer();
    repeat (8)
    begin
      @(negedge clk);
      check_val("o_dispatch_packet_available", 64'd0, 64'(available));
    end
  endtask

  task automatic run_frame(input logic bad);
    int         len;
    logic [7:0] keep;
    pick_frame(len, keep);
    send_frame(len, keep, bad);
    if (bad)
      watch_no_offer();
    else
    begin
      wait_available();
      read_frame();
      discard_frame();
    end
  endtask

  // ------------------------------------------------------------------
  // Register API
  // ------------------------------------------------------------------
  task automatic api_write(input logic [11:0] addr, input logic [31:0] data);
    after_edge();
    api_cs    = 1'b1;
    api_we    = 1'b1;
    api_addr  = addr;
    api_wdata = data;
    after_edge();
    api_cs = 1'b0;
    api_we = 1'b0;
  endtask

  task automatic api_read(input logic [11:0] addr, output logic [31:0] data);
    after_edge();
    api_cs   = 1'b1;
    api_we   = 1'b0;
    api_addr = addr;
    @(negedge clk);
    data = api_rdata;
    after_edge();
    api_cs = 1'b0;
  endtask

  // MSB first so the LSB read returns the snapshot
  task automatic check_counter(input string name, input logic [11:0] msb_addr,
                               input logic [63:0] exp);
    logic [31:0] hi;
    logic [31:0] lo;
    api_read(msb_addr, hi);
    api_read(msb_addr + 12'd1, lo);
    check_val(name, exp, {hi, lo});
  endtask

  task automatic check_all_counters();
    check_counter("frames counter", ADDR_FRAMES_MSB, exp_frames);
    check_counter("good counter", ADDR_GOOD_MSB, exp_good);
    check_counter("bad counter", ADDR_BAD_MSB, exp_bad);
    check_counter("dispatched counter", ADDR_DISPATCHED_MSB, exp_disp);
    check_counter("bytes counter", ADDR_BYTES_MSB, exp_bytes);
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial
  begin
    logic [31:0] rd;
    logic [31:0] scratch;
    int          len;
    logic [7:0]  keep;
    int          err0;
    int          n;
    lfsr            = 32'd70894;
    rx_data         = '0;
    rx_keep         = '0;
    rx_good         = 1'b0;
    rx_bad          = 1'b0;
    rd_start        = 1'b0;
    discard         = 1'b0;
    api_cs          = 1'b0;
    api_we          = 1'b0;
    api_addr        = '0;
    api_wdata       = '0;
    model_prev_keep = 8'hFF;
    exp_frames      = '0;
    exp_good        = '0;
    exp_bad         = '0;
    exp_disp        = '0;
    exp_bytes       = '0;
    checks          = 0;
    errors          = 0;

    n = 0;
    @(negedge clk);
    while (areset)
    begin
      n++;
      if (n > WAIT_LIMIT)
        give_up("waiting for reset release");
      @(negedge clk);
    end

    err0 = errors;
    check_val("o_dispatch_packet_available", 64'd0, 64'(available));
    check_val("o_dispatch_fifo_empty", 64'd1, 64'(fifo_empty));
    check_val("o_dispatch_fifo_rd_valid", 64'd0, 64'(rd_valid));
    check_all_counters();
    report_test("[1] reset state", err0);

    err0 = errors;
    api_read(ADDR_NAME0, rd);
    check_val("o_api_read_data", 64'h4E54_532D, 64'(rd));   // NTS-
    api_read(ADDR_NAME1, rd);
    check_val("o_api_read_data", 64'h4449_5350, 64'(rd));   // DISP
    api_read(ADDR_VERSION, rd);
    check_val("o_api_read_data", 64'h302E_3032, 64'(rd));   // 0.02
    scratch = 32'(take_bits(32));
    api_write(ADDR_DUMMY, scratch);
    api_read(ADDR_DUMMY, rd);
    check_val("o_api_read_data", 64'(scratch), 64'(rd));
    api_read(12'h5A4, rd);
    check_val("o_api_read_data", 64'd0, 64'(rd));
    report_test("[2] identity and scratch", err0);

    err0 = errors;
    repeat (6)
      run_frame(1'b0);
    report_test("[3] frame loopback", err0);

    // Second frame lands while the first is still offered
    err0 = errors;
    pick_frame(len, keep);
    send_frame(len, keep, 1'b0);
    wait_available();
    pick_frame(len, keep);
    send_frame(len, keep, 1'b0);
    read_frame();
    discard_frame();
    wait_available();
    read_frame();
    discard_frame();
    // Long frame cut off in the middle of its stream
    pick_frame(len, keep);
    send_frame(12, keep, 1'b0);
    wait_available();
    cut_frame();
    report_test("[4] double buffering", err0);

    err0 = errors;
    run_frame(1'b1);
    run_frame(1'b0);
    report_test("[5] bad frame", err0);

    err0 = errors;
    for (int f = 0; f < NUM_FRAMES; f++)
      run_frame(take_bits(2) == 64'd0);
    check_all_counters();
    report_test("[6] random frames and statistics", err0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* nts_dispatcher.f */
common/nts_frame_pkg.sv
common/nts_api_pkg.sv
rx/nts_rx_frontend.sv
buffer/nts_bank_ram.sv
buffer/nts_frame_buffer.sv
logic/nts_api_regs.sv
logic/nts_dispatcher.sv
sim/tb_clkgen.sv
sim/nts_dispatcher_assert.sv
sim/tb_nts_dispatcher.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/10ps -j 0
TOP       = tb_nts_dispatcher
FILELIST  = nts_dispatcher.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
